//--- rv_pkg.sv
// ####################
// shared types, encodings and constants for the rv32i subset pipeline
// import with rv_pkg::* in each module header
// ####################
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;    // data, address or instruction
  typedef logic [4:0]  reg_idx_t; // architectural register index

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add       = 4'd0,
    alu_sub       = 4'd1,
    alu_and       = 4'd2,
    alu_or        = 4'd3,
    alu_xor       = 4'd4,
    alu_sll       = 4'd5,
    alu_srl       = 4'd6,
    alu_pass_zero = 4'd7  // ecall and bubbles
  } alu_fn_e;

  // operand source picked by forwarding in execute
  typedef enum logic [1:0] {
    fwd_reg   = 2'd0,
    fwd_wb    = 2'd1,
    fwd_exmem = 2'd2,
    fwd_hist  = 2'd3
  } fwd_sel_e;

  typedef enum logic [1:0] {
    run    = 2'd0,
    drain  = 2'd1,
    halted = 2'd2
  } halt_state_e;

  localparam reg_idx_t ecall_reg = 5'd17; // a7 holds the ecall code
  localparam word_t    halt_code = 32'd10;

endpackage

`default_nettype wire

//--- rv_intf.sv
// ####################
// decoded instruction from the decode/execute register into execute
// ####################
`timescale 1ns/1ps
`default_nettype none

interface dec_ex_if
  import rv_pkg::*;
();

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    imm;
  alu_fn_e  alu_fn;
  logic     use_imm;   // second ALU operand is imm
  logic     mem_read;
  logic     mem_write;
  logic     reg_write;
  logic     is_ecall;  // all control bits low means bubble

  modport dec (
    output rs1, rs2, rd, rs1_val, rs2_val, imm, alu_fn,
    output use_imm, mem_read, mem_write, reg_write, is_ecall
  );

  modport ex (
    input rs1, rs2, rd, rs1_val, rs2_val, imm, alu_fn,
    input use_imm, mem_read, mem_write, reg_write, is_ecall
  );

endinterface

`default_nettype wire

//--- fetch_stage.sv
// ####################
// program counter and fetch/decode register, both held on stall
// ####################
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import rv_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  output word_t imem_addr,
  input  word_t imem_rdata,
  output word_t inst
);

  word_t pc;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= reset_pc;
      inst <= '0;  // opcode 0 decodes as a bubble
    end else if (!stall) begin
      pc   <= pc + 32'd4;
      inst <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- decode_stage.sv
// ####################
// control decode, immediates, register file and load-use / halt stall
// drives the decode/execute register through dec_ex_if.dec
// ####################
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    inst,
  input  logic     freeze,
  input  reg_idx_t exmem_rd,
  input  reg_idx_t wb_rd,
  input  logic     wb_write,
  input  word_t    wb_data,
  output logic     stall,
  dec_ex_if.dec    dx
);

  word_t      regs [32];
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm;
  alu_fn_e    alu_fn;
  logic       use_imm;
  logic       mem_read;
  logic       mem_write;
  logic       reg_write;
  logic       is_ecall;
  logic       uses_rs2;
  logic       load_use;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    alu_fn    = alu_pass_zero;
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    is_ecall  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      op_reg: begin
        uses_rs2  = 1'b1;
        reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
        case (funct3)
          3'b000: begin
            if (funct7[5]) alu_fn = alu_sub;
            else alu_fn = alu_add;
          end
          3'b001:  alu_fn = alu_sll;
          3'b100:  alu_fn = alu_xor;
          3'b101:  alu_fn = alu_srl;
          3'b110:  alu_fn = alu_or;
          3'b111:  alu_fn = alu_and;
          default: reg_write = 1'b0;  // slt family not kept
        endcase
      end
      op_imm: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000: alu_fn = alu_add;
          3'b100: alu_fn = alu_xor;
          3'b110: alu_fn = alu_or;
          3'b111: alu_fn = alu_and;
          3'b001: begin
            alu_fn    = alu_sll;
            reg_write = (funct7 == 7'b0000000);
          end
          3'b101: begin
            alu_fn    = alu_srl;
            reg_write = (funct7 == 7'b0000000);  // srai dropped
          end
          default: reg_write = 1'b0;
        endcase
      end
      op_load: begin
        if (funct3 == 3'b010) begin  // lw only
          alu_fn    = alu_add;
          use_imm   = 1'b1;
          mem_read  = 1'b1;
          reg_write = 1'b1;
        end
      end
      op_store: begin
        if (funct3 == 3'b010) begin  // sw only
          alu_fn    = alu_add;
          use_imm   = 1'b1;
          mem_write = 1'b1;
          uses_rs2  = 1'b1;
        end
      end
      op_system: is_ecall = (inst[31:7] == '0);
      default: ;
    endcase
  end

  // S format for stores, I format for everything else
  assign imm = (opcode == op_store) ? {{20{inst[31]}}, inst[31:25], inst[11:7]}
                                    : {{20{inst[31]}}, inst[31:20]};

  assign rs1 = is_ecall ? ecall_reg : inst[19:15];
  assign rs2 = inst[24:20];

  // load sitting in execute, seen through our own register
  assign load_use = dx.mem_read && (dx.rd != '0) &&
                    ((dx.rd == rs1) || (uses_rs2 && dx.rd == rs2));
  assign stall = freeze || load_use;

  // write at the edge, read sees the old value in the same cycle
  always_ff @(posedge clk) begin
    if (wb_write && wb_rd != '0) regs[wb_rd] <= wb_data;
  end

  always_ff @(posedge clk) begin
    if (reset || stall) begin
      dx.use_imm   <= 1'b0;
      dx.mem_read  <= 1'b0;
      dx.mem_write <= 1'b0;
      dx.reg_write <= 1'b0;
      dx.is_ecall  <= 1'b0;
      dx.alu_fn    <= alu_pass_zero;
    end else begin
      dx.use_imm   <= use_imm;
      dx.mem_read  <= mem_read;
      dx.mem_write <= mem_write;
      dx.reg_write <= reg_write;
      dx.is_ecall  <= is_ecall;
      dx.alu_fn    <= alu_fn;
    end
  end

  always_ff @(posedge clk) begin
    dx.rs1     <= rs1;
    dx.rs2     <= rs2;
    dx.rd      <= inst[11:7];
    dx.rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
    dx.rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
    dx.imm     <= imm;
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
// ####################
// operand forwarding, ALU and the execute/memory register
// data memory strobes come straight from that register
// ####################
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  dec_ex_if.ex     dx,
  input  reg_idx_t wb_rd,
  input  logic     wb_write,
  input  word_t    wb_data,
  input  reg_idx_t hist_rd,
  input  logic     hist_write,
  input  word_t    hist_data,
  output word_t    ecall_x17,
  output logic     is_ecall,
  output reg_idx_t exmem_rd,
  output logic     exmem_write,
  output logic     exmem_load,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output logic     dmem_read,
  output logic     dmem_write
);

  fwd_sel_e sel_a;
  fwd_sel_e sel_b;
  word_t    op_a;
  word_t    rs2_fwd;
  word_t    op_b;
  word_t    alu_out;
  word_t    result_q;
  word_t    wdata_q;
  logic     load_q;
  logic     store_q;

  // youngest writer wins
  function automatic fwd_sel_e pick_src(input reg_idx_t rs);
    if (rs == '0) return fwd_reg;
    if (exmem_write && exmem_rd == rs) return fwd_exmem;
    if (wb_write && wb_rd == rs) return fwd_wb;
    if (hist_write && hist_rd == rs) return fwd_hist;
    return fwd_reg;
  endfunction

  function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
    case (sel)
      fwd_exmem: return result_q;
      fwd_wb:    return wb_data;
      fwd_hist:  return hist_data;
      default:   return reg_val;
    endcase
  endfunction

  always_comb begin
    sel_a   = pick_src(dx.rs1);
    sel_b   = pick_src(dx.rs2);
    op_a    = fwd_value(sel_a, dx.rs1_val);
    rs2_fwd = fwd_value(sel_b, dx.rs2_val);
    op_b    = dx.use_imm ? dx.imm : rs2_fwd;
  end

  always_comb begin
    case (dx.alu_fn)
      alu_add: alu_out = op_a + op_b;
      alu_sub: alu_out = op_a - op_b;
      alu_and: alu_out = op_a & op_b;
      alu_or:  alu_out = op_a | op_b;
      alu_xor: alu_out = op_a ^ op_b;
      alu_sll: alu_out = op_a << op_b[4:0];  // low five bits only
      alu_srl: alu_out = op_a >> op_b[4:0];
      default: alu_out = '0;
    endcase
  end

  // rs1 of an ecall is x17
  assign ecall_x17 = op_a;
  assign is_ecall  = dx.is_ecall;

  always_ff @(posedge clk) begin
    if (reset) begin
      exmem_write <= 1'b0;
      load_q      <= 1'b0;
      store_q     <= 1'b0;
    end else begin
      exmem_write <= dx.reg_write;
      load_q      <= dx.mem_read;
      store_q     <= dx.mem_write;
    end
  end

  always_ff @(posedge clk) begin
    exmem_rd <= dx.rd;
    result_q <= alu_out;
    wdata_q  <= rs2_fwd;  // store data after forwarding
  end

  assign exmem_load = load_q;
  assign dmem_read  = load_q;
  assign dmem_write = store_q;
  assign dmem_addr  = result_q;
  assign dmem_wdata = wdata_q;

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
// ####################
// memory/writeback register, writeback mux and one-entry history
// ####################
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t exmem_rd,
  input  logic     exmem_write,
  input  logic     exmem_load,
  input  word_t    exmem_result,
  input  word_t    dmem_rdata,
  output reg_idx_t wb_rd,
  output logic     wb_write,
  output word_t    wb_data,
  output reg_idx_t hist_rd,
  output logic     hist_write,
  output word_t    hist_data
);

  logic  load_q;
  word_t result_q;
  word_t rdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write   <= 1'b0;
      load_q     <= 1'b0;
      hist_write <= 1'b0;
    end else begin
      wb_write   <= exmem_write;
      load_q     <= exmem_load;
      hist_write <= wb_write;  // last cycle's writeback
    end
  end

  always_ff @(posedge clk) begin
    wb_rd     <= exmem_rd;
    result_q  <= exmem_result;
    rdata_q   <= dmem_rdata;
    hist_rd   <= wb_rd;
    hist_data <= wb_data;
  end

  assign wb_data = load_q ? rdata_q : result_q;

endmodule

`default_nettype wire

//--- halt_unit.sv
// ####################
// halting ecall detect, then drain_cycles edges before halted rises
// ####################
`timescale 1ns/1ps
`default_nettype none

module halt_unit
  import rv_pkg::*;
#(
  parameter int unsigned drain_cycles = 2
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  is_ecall,
  input  word_t ecall_x17,
  output logic  freeze,
  output logic  halted
);

  localparam int cnt_w = (drain_cycles > 1) ? $clog2(drain_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(drain_cycles - 1);

  halt_state_e      state;
  logic [cnt_w-1:0] cnt;
  logic             halt_hit;

  assign halt_hit = is_ecall && (ecall_x17 == halt_code);
  assign freeze   = (state != run) || halt_hit;  // same cycle as the ecall in execute
  assign halted   = (state == rv_pkg::halted);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= run;
      cnt   <= '0;
    end else begin
      case (state)
        run: begin
          if (halt_hit) state <= drain;
          cnt <= '0;
        end
        drain: begin
          if (cnt == cnt_last) state <= rv_pkg::halted;
          else cnt <= cnt + 1'b1;
        end
        default: state <= rv_pkg::halted;  // sticky until reset
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rv_core.sv
// ####################
// five-stage rv32i subset core, instruction and data memories outside
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter word_t       reset_pc     = '0,
  parameter int unsigned drain_cycles = 2
) (
  input  logic  clk,
  input  logic  reset,
  output word_t imem_addr,
  input  word_t imem_rdata,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_read,
  output logic  dmem_write,
  input  word_t dmem_rdata,
  output logic  halted
);

  word_t    inst;
  logic     stall;
  logic     freeze;
  word_t    ecall_x17;
  logic     is_ecall;
  reg_idx_t exmem_rd;
  logic     exmem_write;
  logic     exmem_load;
  reg_idx_t wb_rd;
  logic     wb_write;
  word_t    wb_data;
  reg_idx_t hist_rd;
  logic     hist_write;
  word_t    hist_data;

  dec_ex_if dec_ex ();

  // stall already includes freeze
  fetch_stage #(
    .reset_pc(reset_pc)
  ) fetch0 (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .inst       (inst)
  );

  decode_stage decode0 (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .freeze   (freeze),
    .exmem_rd (exmem_rd),
    .wb_rd    (wb_rd),
    .wb_write (wb_write),
    .wb_data  (wb_data),
    .stall    (stall),
    .dx       (dec_ex.dec)
  );

  execute_stage execute0 (
    .clk         (clk),
    .reset       (reset),
    .dx          (dec_ex.ex),
    .wb_rd       (wb_rd),
    .wb_write    (wb_write),
    .wb_data     (wb_data),
    .hist_rd     (hist_rd),
    .hist_write  (hist_write),
    .hist_data   (hist_data),
    .ecall_x17   (ecall_x17),
    .is_ecall    (is_ecall),
    .exmem_rd    (exmem_rd),
    .exmem_write (exmem_write),
    .exmem_load  (exmem_load),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_read   (dmem_read),
    .dmem_write  (dmem_write)
  );

  mem_wb_stage mem_wb0 (
    .clk          (clk),
    .reset        (reset),
    .exmem_rd     (exmem_rd),
    .exmem_write  (exmem_write),
    .exmem_load   (exmem_load),
    .exmem_result (dmem_addr),  // ALU result doubles as the address
    .dmem_rdata   (dmem_rdata),
    .wb_rd        (wb_rd),
    .wb_write     (wb_write),
    .wb_data      (wb_data),
    .hist_rd      (hist_rd),
    .hist_write   (hist_write),
    .hist_data    (hist_data)
  );

  halt_unit #(
    .drain_cycles(drain_cycles)
  ) halt0 (
    .clk       (clk),
    .reset     (reset),
    .is_ecall  (is_ecall),
    .ecall_x17 (ecall_x17),
    .freeze    (freeze),
    .halted    (halted)
  );

endmodule

`default_nettype wire

//--- rv_core_assert.sv
// ####################
// port-level concurrent checks, bound into every rv_core instance
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert
  import rv_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  halted,
  input logic  dmem_read,
  input logic  dmem_write,
  input word_t imem_addr
);

  int unsigned fail_count = 0;  // polled by the testbench

  // halted only clears through reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else begin
      $error("halted dropped without reset");
      fail_count++;
    end

  no_read_write: assert property (@(posedge clk) disable iff (reset)
    !(dmem_read && dmem_write))
    else begin
      $error("dmem_read and dmem_write high together");
      fail_count++;
    end

  pc_frozen: assert property (@(posedge clk) disable iff (reset)
    halted |=> $stable(imem_addr))  // fetch held by freeze
    else begin
      $error("imem_addr moved while halted");
      fail_count++;
    end

endmodule

bind rv_core rv_core_assert assert0 (
  .clk        (clk),
  .reset      (reset),
  .halted     (halted),
  .dmem_read  (dmem_read),
  .dmem_write (dmem_write),
  .imem_addr  (imem_addr)
);

`default_nettype wire

//--- rv_core_tb.sv
// ####################
// testbench for rv_core with instruction and data memory models
// runs a fixed program and checks every store until halted
// ####################
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  localparam int         mem_words = 64;
  localparam logic [6:0] opc_reg   = 7'b0110011;
  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam word_t      ecall     = 32'h0000_0073;
  localparam word_t      nop       = 32'h0000_0013;  // addi x0, x0, 0

  logic        clk;
  logic        reset;
  word_t       imem_addr;
  word_t       imem_rdata;
  word_t       dmem_addr;
  word_t       dmem_wdata;
  logic        dmem_read;
  logic        dmem_write;
  word_t       dmem_rdata;
  logic        halted;
  word_t       imem [mem_words];
  word_t       dmem [mem_words];
  word_t       prog [$];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  int          seen = 0;
  int          cycles = 0;
  int          cycle_limit;

  rv_core #(
    .reset_pc     (32'h0),
    .drain_cycles (2)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  always #4 clk = ~clk;

  // both memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem_read ? dmem[dmem_addr[7:2]] : '0;

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic build_program();
    prog.push_back(enc_i(opc_imm, 3'b000, 1, 0, 12'h123));    // x1 = 0x123
    prog.push_back(enc_i(opc_imm, 3'b000, 2, 1, 12'h045));    // exmem forward
    prog.push_back(enc_i(opc_imm, 3'b001, 3, 1, 12'h004));    // slli, wb forward
    prog.push_back(enc_r(7'h00, 3'b000, 4, 1, 2));            // x1 from history
    prog.push_back(enc_r(7'h20, 3'b000, 5, 4, 3));            // sub
    prog.push_back(enc_r(7'h00, 3'b100, 6, 5, 2));            // xor
    prog.push_back(enc_i(opc_imm, 3'b101, 7, 6, 12'h008));    // srli
    prog.push_back(enc_i(opc_imm, 3'b000, 9, 0, 12'd36));     // shift 36, low bits 4
    prog.push_back(enc_r(7'h00, 3'b001, 10, 4, 9));           // sll
    prog.push_back(enc_r(7'h00, 3'b101, 11, 6, 9));           // srl
    prog.push_back(enc_r(7'h00, 3'b111, 12, 11, 7));          // and
    prog.push_back(enc_r(7'h00, 3'b110, 13, 12, 10));         // or
    prog.push_back(enc_i(opc_imm, 3'b100, 14, 13, 12'hfff));  // xori -1
    prog.push_back(enc_i(opc_imm, 3'b111, 15, 14, 12'h7f0));  // andi
    prog.push_back(enc_i(opc_imm, 3'b110, 16, 15, 12'h00f));  // ori
    prog.push_back(enc_i(opc_imm, 3'b000, 20, 0, 12'h0c0));   // store base
    prog.push_back(enc_s(4, 20, 12'd0));
    prog.push_back(enc_s(5, 20, 12'd4));
    prog.push_back(enc_s(10, 20, 12'd8));
    prog.push_back(enc_s(11, 20, 12'hffc));                   // offset -4
    prog.push_back(enc_s(13, 20, 12'hfc0));                   // offset -64
    prog.push_back(enc_s(16, 20, 12'd12));
    prog.push_back(enc_i(opc_imm, 3'b000, 21, 14, 12'h010));
    prog.push_back(enc_s(21, 20, 12'd16));                    // store data forwarded
    prog.push_back(enc_i(opc_imm, 3'b000, 0, 0, 12'h055));    // write to x0
    prog.push_back(enc_s(0, 20, 12'd20));
    prog.push_back(enc_i(opc_load, 3'b010, 23, 0, 12'h008));  // lw word 2
    prog.push_back(enc_r(7'h00, 3'b000, 24, 23, 1));          // load-use
    prog.push_back(enc_s(24, 20, 12'd24));
    prog.push_back(enc_i(opc_load, 3'b010, 25, 0, 12'h07c));  // lw word 31
    prog.push_back(enc_s(25, 20, 12'd28));                    // load-use on store data
    prog.push_back(enc_i(opc_imm, 3'b000, 17, 0, 12'd10));    // older x17, sits in wb then hist
    prog.push_back(enc_i(opc_imm, 3'b000, 17, 0, 12'd9));     // exmem must win
    prog.push_back(ecall);                                    // no halt
    prog.push_back(enc_s(17, 20, 12'd32));                    // wb must beat history
    prog.push_back(enc_i(opc_imm, 3'b000, 17, 0, 12'd10));
    prog.push_back(ecall);                                    // halts
    prog.push_back(enc_s(1, 20, 12'd36));                     // never stored
    prog.push_back(enc_s(2, 20, 12'd40));
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // worked by hand from the instruction semantics
  task automatic build_expected();
    expect_store(32'h0c0, 32'h0000_028b);
    expect_store(32'h0c4, 32'hffff_f05b);
    expect_store(32'h0c8, 32'h0000_28b0);
    expect_store(32'h0bc, 32'h0fff_ff13);
    expect_store(32'h080, 32'h00ff_ffb1);
    expect_store(32'h0cc, 32'h0000_004f);
    expect_store(32'h0d0, 32'hff00_005e);
    expect_store(32'h0d4, 32'h0000_0000);
    expect_store(32'h0d8, dmem[2] + 32'h123);
    expect_store(32'h0dc, dmem[31]);
    expect_store(32'h0e0, 32'h0000_0009);
  endtask

  always @(posedge clk) cycles <= cycles + 1;

  // store commits at the edge where dmem_write is high
  always @(posedge clk) begin
    if (!reset && dmem_write) begin
      if (seen >= exp_addr.size()) begin
        fail_run($sformatf("unexpected store of %h to address %h", dmem_wdata, dmem_addr));
      end else begin
        check_value($sformatf("store%0d_addr", seen), exp_addr[seen], dmem_addr);
        check_value($sformatf("store%0d_data", seen), exp_data[seen], dmem_wdata);
        dmem[dmem_addr[7:2]] <= dmem_wdata;
        seen = seen + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (dut0.assert0.fail_count != 0) begin
      fail_run("a bound assertion on rv_core fired");
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    void'($urandom(32'h6d1f_9aae));
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = nop;
      dmem[i] = $urandom;
    end
    build_program();
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    build_expected();
    cycle_limit = prog.size() * 4 + 50;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    while (!halted && cycles < cycle_limit) @(negedge clk);
    if (!halted) begin
      fail_run($sformatf("timeout, halted still low after %0d cycles", cycles));
    end else begin
      repeat (4) @(negedge clk);  // late stores would show here
      if (seen == exp_addr.size()) begin
        $display("test passed");
        $finish;
      end else begin
        fail_run($sformatf("only %0d of %0d expected stores seen before halt",
                           seen, exp_addr.size()));
      end
    end
  end

endmodule

`default_nettype wire

//--- files.f
rv_pkg.sv
rv_intf.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
halt_unit.sv
rv_core.sv
rv_core_assert.sv
rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_intf.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - halt_unit.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_assert.sv
      - rv_core_tb.sv
